//--- verilog/sobelPkg.sv
package sobelPkg;

    // Camera pixel and line geometry
    localparam int PixelWidth = 8;
    localparam int LineWidth = 64;
    localparam int ColWidth = $clog2(LineWidth);

    // Packed edge output
    localparam int WordWidth = 32;
    localparam int WordCountWidth = $clog2(WordWidth);

    // Gradient range is +/-1020 for 8-bit pixels
    localparam int GradWidth = 12;
    localparam int ThresholdWidth = 12;

    typedef logic [PixelWidth-1:0] pixelT;

    // Indexed [row][column], row 0 oldest, column 0 leftmost
    typedef pixelT [2:0][2:0] windowT;

    typedef logic signed [GradWidth-1:0] gradT;

endpackage

//--- verilog/lineWindow.sv
`timescale 1ns/1ps

module lineWindow
    import sobelPkg::*;
(
    input  logic   camClock,
    input  logic   arstN,
    input  logic   pixelValid,
    input  pixelT  pixelData,
    input  logic   hsync,
    input  logic   vsync,
    output logic   windowValid,
    output windowT window,
    output logic   windowEdge,
    output logic   rowStart
);

    logic [ColWidth-1:0] column;
    logic [1:0]          row;

    // Two previous rows, newest and older
    pixelT newestLine [LineWidth];
    pixelT olderLine  [LineWidth];

    // Read stage registers
    pixelT pixelReg;
    pixelT newestReg;
    pixelT olderReg;
    logic  stageValid;
    logic  stageEdge;
    logic  stageRowStart;

    // Position counters, row saturates at 2
    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            column <= '0;
            row <= '0;
        end else if (vsync) begin
            column <= '0;
            row <= '0;
        end else if (hsync) begin
            column <= '0;
            if (row != 2'd2) begin
                row <= row + 2'd1;
            end
        end else if (pixelValid) begin
            column <= column + ColWidth'(1);
        end
    end

    // Line buffers, displaced pixel drops into the older row
    always_ff @(posedge camClock) begin
        if (pixelValid) begin
            newestLine[column] <= pixelData;
            olderLine[column] <= newestLine[column];
            newestReg <= newestLine[column];
            olderReg <= olderLine[column];
            pixelReg <= pixelData;
        end
    end

    // Only rows 2 and later produce a window
    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            stageValid <= 1'b0;
            stageEdge <= 1'b0;
            stageRowStart <= 1'b0;
            windowValid <= 1'b0;
            windowEdge <= 1'b0;
            rowStart <= 1'b0;
        end else begin
            stageValid <= pixelValid && row == 2'd2;
            stageEdge <= column < ColWidth'(2) || row < 2'd2;
            stageRowStart <= hsync || vsync;
            windowValid <= stageValid;
            windowEdge <= stageEdge;
            rowStart <= stageRowStart;
        end
    end

    always_ff @(posedge camClock) begin
        if (stageValid) begin
            for (int r = 0; r < 3; r++) begin
                window[r][0] <= window[r][1];
                window[r][1] <= window[r][2];
            end
            window[0][2] <= olderReg;
            window[1][2] <= newestReg;
            window[2][2] <= pixelReg;
        end
    end

endmodule

//--- verilog/sobelKernel.sv
`timescale 1ns/1ps

module sobelKernel
    import sobelPkg::*;
(
    input  logic                      camClock,
    input  logic                      arstN,
    input  logic                      windowValid,
    input  windowT                    window,
    input  logic                      windowEdge,
    input  logic [ThresholdWidth-1:0] threshold,
    output logic                      bitValid,
    output logic                      edgeBit
);

    gradT leftSum;
    gradT rightSum;
    gradT topSum;
    gradT bottomSum;
    gradT gradX;
    gradT gradY;

    logic [GradWidth-1:0]      absX;
    logic [GradWidth-1:0]      absY;
    logic [ThresholdWidth-1:0] magnitude;
    logic                      isEdge;

    // 1 2 1 weighting of three pixels
    function automatic gradT weighted(input pixelT a, input pixelT b, input pixelT c);
        return gradT'(a) + (gradT'(b) << 1) + gradT'(c);
    endfunction

    assign leftSum = weighted(window[0][0], window[1][0], window[2][0]);
    assign rightSum = weighted(window[0][2], window[1][2], window[2][2]);
    assign topSum = weighted(window[0][0], window[0][1], window[0][2]);
    assign bottomSum = weighted(window[2][0], window[2][1], window[2][2]);

    assign gradX = rightSum - leftSum;
    assign gradY = bottomSum - topSum;

    assign absX = gradX[GradWidth-1] ? -gradX : gradX;
    assign absY = gradY[GradWidth-1] ? -gradY : gradY;

    // At most 2040, no carry out of 12 bits
    assign magnitude = absX + absY;
    assign isEdge = magnitude > threshold && !windowEdge;

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            bitValid <= 1'b0;
        end else begin
            bitValid <= windowValid;
        end
    end

    always_ff @(posedge camClock) begin
        if (windowValid) begin
            edgeBit <= isEdge;
        end
    end

endmodule

//--- verilog/edgePacker.sv
`timescale 1ns/1ps

module edgePacker
    import sobelPkg::*;
(
    input  logic                 camClock,
    input  logic                 arstN,
    input  logic                 bitValid,
    input  logic                 edgeBit,
    input  logic                 rowStart,
    output logic                 edgeReq,
    output logic [WordWidth-1:0] edgeWord,
    input  logic                 edgeAck,
    output logic                 overrun
);

    logic [WordWidth-1:0]      shiftWord;
    logic [WordWidth-1:0]      nextWord;
    logic [WordCountWidth-1:0] bitCount;
    logic                      wordDone;
    logic                      canSend;

    // Earliest bit ends up in the MSB
    assign nextWord = {shiftWord[WordWidth-2:0], edgeBit};
    assign wordDone = bitValid && bitCount == WordCountWidth'(WordWidth - 1);

    // Idle only once the previous ack has dropped
    assign canSend = !edgeReq && !edgeAck;

    always_ff @(posedge camClock) begin
        if (bitValid) begin
            shiftWord <= nextWord;
        end
        if (wordDone && canSend) begin
            edgeWord <= nextWord;
        end
    end

    always_ff @(posedge camClock or negedge arstN) begin
        if (!arstN) begin
            bitCount <= '0;
            edgeReq <= 1'b0;
            overrun <= 1'b0;
        end else begin
            // A bit arriving with rowStart still closes the old row
            if (rowStart) begin
                bitCount <= '0;
            end else if (bitValid) begin
                bitCount <= bitCount + WordCountWidth'(1);
            end

            if (wordDone && canSend) begin
                edgeReq <= 1'b1;
            end else if (edgeReq && edgeAck) begin
                edgeReq <= 1'b0;
            end

            // Word lost, stream cannot stall
            if (wordDone && !canSend) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/sobelEdgeTop.sv
`timescale 1ns/1ps

module sobelEdgeTop
    import sobelPkg::*;
(
    input  logic                      camClock,
    input  logic                      arstN,
    input  logic                      pixelValid,
    input  pixelT                     pixelData,
    input  logic                      hsync,
    input  logic                      vsync,
    input  logic [ThresholdWidth-1:0] threshold,
    output logic                      edgeReq,
    output logic [WordWidth-1:0]      edgeWord,
    input  logic                      edgeAck,
    output logic                      overrun
);

    logic   windowValid;
    windowT window;
    logic   windowEdge;
    logic   rowStart;
    logic   bitValid;
    logic   edgeBit;

    lineWindow window_i (
        .camClock    (camClock),
        .arstN       (arstN),
        .pixelValid  (pixelValid),
        .pixelData   (pixelData),
        .hsync       (hsync),
        .vsync       (vsync),
        .windowValid (windowValid),
        .window      (window),
        .windowEdge  (windowEdge),
        .rowStart    (rowStart)
    );

    sobelKernel kernel_i (
        .camClock    (camClock),
        .arstN       (arstN),
        .windowValid (windowValid),
        .window      (window),
        .windowEdge  (windowEdge),
        .threshold   (threshold),
        .bitValid    (bitValid),
        .edgeBit     (edgeBit)
    );

    edgePacker packer_i (
        .camClock (camClock),
        .arstN    (arstN),
        .bitValid (bitValid),
        .edgeBit  (edgeBit),
        .rowStart (rowStart),
        .edgeReq  (edgeReq),
        .edgeWord (edgeWord),
        .edgeAck  (edgeAck),
        .overrun  (overrun)
    );

endmodule

//--- test/sobelEdge_asserts.sv
`timescale 1ns/1ps

module edgePackerAsserts
    import sobelPkg::*;
(
    input logic                 camClock,
    input logic                 arstN,
    input logic                 edgeReq,
    input logic [WordWidth-1:0] edgeWord,
    input logic                 edgeAck
);

    resetLow: assert property (@(posedge camClock) !arstN |-> !edgeReq)
        else $error("edgeReq high during reset");

    holdUntilAck: assert property (@(posedge camClock) disable iff (!arstN)
        edgeReq && !edgeAck |=> edgeReq)
        else $error("edgeReq dropped before edgeAck");

    wordStable: assert property (@(posedge camClock) disable iff (!arstN)
        edgeReq |=> !edgeReq || $stable(edgeWord))
        else $error("edgeWord changed while edgeReq was high");

    // New request only after the previous ack went low
    noRiseOnAck: assert property (@(posedge camClock) disable iff (!arstN)
        $rose(edgeReq) |-> !$past(edgeAck))
        else $error("edgeReq rose while edgeAck was high");

endmodule

bind edgePacker edgePackerAsserts asserts_i (
    .camClock (camClock),
    .arstN    (arstN),
    .edgeReq  (edgeReq),
    .edgeWord (edgeWord),
    .edgeAck  (edgeAck)
);

//--- test/sobelEdgeTb.sv
`timescale 1ns/1ps

module sobelEdgeTb
    import sobelPkg::*;
();

    localparam int MaxRows = 8;
    localparam int DrainLimit = 600;
    localparam int AckLimit = 100;
    localparam int OverrunLimit = 50;

    logic                      camClock;
    logic                      arstN;
    logic                      pixelValid;
    pixelT                     pixelData;
    logic                      hsync;
    logic                      vsync;
    logic [ThresholdWidth-1:0] threshold;
    logic                      edgeReq;
    logic [WordWidth-1:0]      edgeWord;
    logic                      edgeAck;
    logic                      overrun;

    // Frame image as sent by row and column
    int                   img [MaxRows][LineWidth];
    logic [WordWidth-1:0] expectedWords [$];
    logic                 ackHold;
    logic                 reqSeen;

    sobelEdgeTop dut_i (
        .camClock   (camClock),
        .arstN      (arstN),
        .pixelValid (pixelValid),
        .pixelData  (pixelData),
        .hsync      (hsync),
        .vsync      (vsync),
        .threshold  (threshold),
        .edgeReq    (edgeReq),
        .edgeWord   (edgeWord),
        .edgeAck    (edgeAck),
        .overrun    (overrun)
    );

    always #50 camClock = ~camClock;

    task automatic failRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    // Edge bit for the pixel received at row r and column c
    function automatic logic expectedEdge(input int r, input int c, input int thr);
        int gx;
        int gy;
        int mag;
        if (r < 2 || c < 2) begin
            return 1'b0;
        end
        gx = img[r-2][c] + 2 * img[r-1][c] + img[r][c]
            - img[r-2][c-2] - 2 * img[r-1][c-2] - img[r][c-2];
        gy = img[r][c-2] + 2 * img[r][c-1] + img[r][c]
            - img[r-2][c-2] - 2 * img[r-2][c-1] - img[r-2][c];
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        return mag > thr;
    endfunction

    task automatic fillImage(input int mode);
        for (int r = 0; r < MaxRows; r++) begin
            for (int c = 0; c < LineWidth; c++) begin
                case (mode)
                    0: img[r][c] = 100;
                    1: img[r][c] = c < 30 ? 0 : 200;
                    default: img[r][c] = int'($urandom_range(0, 255));
                endcase
            end
        end
    endtask

    // Whole words only with the leftmost pixel in bit 31
    task automatic buildExpected(input int rows, input int lastLen, input int thr);
        logic [WordWidth-1:0] word;
        int len;
        for (int r = 2; r < rows; r++) begin
            len = (r == rows - 1) ? lastLen : LineWidth;
            for (int w = 0; w < len / WordWidth; w++) begin
                for (int k = 0; k < WordWidth; k++) begin
                    word[WordWidth-1-k] = expectedEdge(r, w * WordWidth + k, thr);
                end
                expectedWords.push_back(word);
            end
        end
    endtask

    task automatic sendPixel(input int value);
        int gap;
        gap = int'($urandom_range(0, 2));
        repeat (gap) begin
            @(posedge camClock);
            #1;
            pixelValid = 1'b0;
        end
        @(posedge camClock);
        #1;
        pixelValid = 1'b1;
        pixelData = pixelT'(value);
    endtask

    task automatic pulseSync(input logic isFrame);
        @(posedge camClock);
        #1;
        pixelValid = 1'b0;
        hsync = !isFrame;
        vsync = isFrame;
        @(posedge camClock);
        #1;
        hsync = 1'b0;
        vsync = 1'b0;
    endtask

    // A short last row is sent without its hsync
    task automatic driveFrame(input int rows, input int lastLen, input int thr);
        int len;
        @(posedge camClock);
        #1;
        threshold = ThresholdWidth'(thr);
        pulseSync(1'b1);
        for (int r = 0; r < rows; r++) begin
            len = (r == rows - 1) ? lastLen : LineWidth;
            for (int c = 0; c < len; c++) begin
                sendPixel(img[r][c]);
            end
            if (len == LineWidth) begin
                pulseSync(1'b0);
            end
        end
        @(posedge camClock);
        #1;
        pixelValid = 1'b0;
    endtask

    task automatic waitDrain();
        int count;
        count = 0;
        @(negedge camClock);
        while (expectedWords.size() != 0 || edgeReq || edgeAck) begin
            if (count == DrainLimit) begin
                failRun("Timeout: expected words were not all delivered");
            end else begin
                count++;
                @(negedge camClock);
            end
        end
    endtask

    task automatic runFrame(input int rows, input int lastLen, input int thr);
        buildExpected(rows, lastLen, thr);
        driveFrame(rows, lastLen, thr);
        waitDrain();
    endtask

    task automatic applyReset();
        arstN = 1'b0;
        repeat (8) @(posedge camClock);
        #1;
        arstN = 1'b1;
    endtask

    // Four-phase acknowledge with a short random delay
    initial begin
        int delay;
        int count;
        edgeAck = 1'b0;
        forever begin
            @(negedge camClock);
            if (edgeReq && !edgeAck && !ackHold) begin
                delay = int'($urandom_range(0, 4));
                repeat (delay) @(posedge camClock);
                @(posedge camClock);
                #1;
                edgeAck = 1'b1;
                count = 0;
                @(negedge camClock);
                while (edgeReq) begin
                    if (count == AckLimit) begin
                        failRun("Timeout: edgeReq did not fall after edgeAck");
                    end else begin
                        count++;
                        @(negedge camClock);
                    end
                end
                @(posedge camClock);
                #1;
                edgeAck = 1'b0;
            end
        end
    end

    // One comparison per rising edgeReq
    initial begin
        reqSeen = 1'b0;
        forever begin
            @(negedge camClock);
            if (edgeReq && !reqSeen) begin
                if (expectedWords.size() == 0) begin
                    failRun("Unexpected output word while none was expected");
                end else begin
                    checkValue("edgeWord", edgeWord, expectedWords.pop_front());
                end
            end
            reqSeen = edgeReq;
        end
    end

    initial begin
        int count;
        void'($urandom(80646));
        camClock = 1'b0;
        pixelValid = 1'b0;
        pixelData = '0;
        hsync = 1'b0;
        vsync = 1'b0;
        threshold = '0;
        ackHold = 1'b0;
        applyReset();

        fillImage(0);
        runFrame(6, LineWidth, 0);
        fillImage(1);
        runFrame(6, LineWidth, 400);
        repeat (3) begin
            fillImage(2);
            runFrame(5, LineWidth, int'($urandom_range(0, 1200)));
        end

        // Row 2 cut after 40 pixels leaves a partial word for the next frame to clear
        fillImage(2);
        runFrame(3, 40, 300);
        fillImage(2);
        runFrame(4, LineWidth, 300);

        // Second word of row 2 completes while the handshake is held open
        fillImage(2);
        ackHold = 1'b1;
        buildExpected(3, LineWidth, 200);
        void'(expectedWords.pop_back());
        driveFrame(3, LineWidth, 200);
        count = 0;
        while (!overrun) begin
            if (count == OverrunLimit) begin
                failRun("Timeout: overrun was not raised while edgeAck was held");
            end else begin
                count++;
                @(posedge camClock);
                #1;
            end
        end
        ackHold = 1'b0;
        waitDrain();
        checkValue("overrun", 32'(overrun), 32'd1);

        fillImage(0);
        runFrame(4, LineWidth, 0);
        checkValue("overrun", 32'(overrun), 32'd1);

        @(posedge camClock);
        #1;
        applyReset();
        checkValue("overrun", 32'(overrun), 32'd0);
        fillImage(1);
        runFrame(5, LineWidth, 400);

        if (expectedWords.size() == 0 && !overrun) begin
            $display(">>> PASS");
            $finish;
        end else begin
            failRun("Words left unchecked or overrun set at the end of the run");
        end
    end

endmodule

//--- flist.f
verilog/sobelPkg.sv
verilog/lineWindow.sv
verilog/sobelKernel.sv
verilog/edgePacker.sv
verilog/sobelEdgeTop.sv
test/sobelEdge_asserts.sv
test/sobelEdgeTb.sv

//--- Makefile
TOP = sobelEdgeTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f flist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
